// File: mem_subsys_top.f
+incdir+verilog
verilog/mem_pkg.sv
verilog/req_fifo.sv
verilog/mem_port_arbiter.sv
verilog/mem_array.sv
verilog/mem_cfg_regs.sv
verilog/mem_subsys_top.sv
verification/mem_subsys_props.sv
verification/mem_subsys_tb.sv

// File: Makefile
TOP = mem_subsys_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f mem_subsys_top.f --top-module $(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1 ; cat sim.log
	@if grep -q "TEST FAILED" sim.log || ! grep -q "TEST PASSED" sim.log; then exit 1; fi

lint:
	verilator --lint-only --timing --assert -f mem_subsys_top.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: verification/mem_subsys_tb.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_subsys_tb;

    localparam int TIMEOUT = 500;
    localparam int NADDR   = 8;
    localparam int IDX_W   = $clog2(`MEM_WORDS);

    logic                   clk;
    logic                   rst;
    logic                   halt;
    logic                   inst_req;
    logic [`MEM_ADDR_W-1:0] inst_addr;
    logic                   inst_credit;
    logic                   inst_rvalid;
    logic [`MEM_DATA_W-1:0] inst_rdata;
    logic                   d_req;
    logic                   d_write;
    logic [`MEM_ADDR_W-1:0] d_addr;
    logic [`MEM_DATA_W-1:0] d_wdata;
    logic [`MEM_DATA_W-1:0] d_wmask;
    logic                   d_credit;
    logic                   d_rvalid;
    logic [`MEM_DATA_W-1:0] d_rdata;
    logic                   cfg_we;
    logic [`CFG_ADDR_W-1:0] cfg_addr;
    logic [`CFG_DATA_W-1:0] cfg_wdata;
    logic [`CFG_DATA_W-1:0] cfg_rdata;

    logic [`MEM_DATA_W-1:0] ref_mem [`MEM_WORDS]; // expected memory contents
    logic [`MEM_ADDR_W-1:0] addrs [NADDR];
    logic [`MEM_DATA_W-1:0] exp_inst [$];
    logic [`MEM_DATA_W-1:0] exp_data [$];
    int                     exp_data_cycle [$];   // request cycle per data read
    int                     inst_spent = 0;
    int                     d_spent = 0;
    int                     inst_back = 0;
    int                     d_back = 0;
    int                     inst_seen = 0;
    int                     d_seen = 0;
    int                     cycle = 0;
    int                     min_lat = 0;
    int                     value_errors = 0;
    int                     check_errors = 0;
    int                     timeouts = 0;
    int                     inst_snap;
    int                     d_snap;
    int                     total;

    mem_subsys_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic int word_idx(input logic [`MEM_ADDR_W-1:0] a);
        return int'(a[IDX_W+1:2]); // upper address bits ignored
    endfunction

    // credits and responses counted mid-cycle where outputs are stable
    always @(negedge clk) begin
        if (!rst) begin
            if (inst_credit) inst_back++;
            if (d_credit) d_back++;
            assert (inst_back <= inst_spent && d_back <= d_spent) else begin
                value_errors++;
                $display("more credits returned than requests issued");
            end
            if (inst_rvalid) begin
                if (inst_seen >= exp_inst.size()) begin
                    value_errors++;
                    $display("inst_rvalid with no fetch outstanding");
                end else begin
                    assert (inst_rdata == exp_inst[inst_seen]) else begin
                        value_errors++;
                        $display("[ERROR] inst_rdata got %h expected %h",
                                 inst_rdata, exp_inst[inst_seen]);
                    end
                    inst_seen++;
                end
            end
            if (d_rvalid) begin
                if (d_seen >= exp_data.size()) begin
                    value_errors++;
                    $display("d_rvalid with no data read outstanding");
                end else begin
                    assert (d_rdata == exp_data[d_seen]) else begin
                        value_errors++;
                        $display("[ERROR] d_rdata got %h expected %h", d_rdata, exp_data[d_seen]);
                    end
                    assert (cycle - exp_data_cycle[d_seen] >= min_lat) else begin
                        value_errors++;
                        $display("[ERROR] d_rvalid latency got %h expected at least %h",
                                 cycle - exp_data_cycle[d_seen], min_lat);
                    end
                    d_seen++;
                end
            end
        end
    end

    // one request cycle on either port or both, once credit is there
    task automatic send(input bit use_i, input logic [`MEM_ADDR_W-1:0] ia, input bit use_d,
                        input bit wr, input logic [`MEM_ADDR_W-1:0] da,
                        input logic [`MEM_DATA_W-1:0] wd, input logic [`MEM_DATA_W-1:0] wm);
        int guard;
        int i;
        guard = 0;
        @(posedge clk);
        #1;
        inst_req = 1'b0;
        d_req    = 1'b0;
        while ((use_i && inst_spent - inst_back >= `REQ_DEPTH) ||
               (use_d && d_spent - d_back >= `REQ_DEPTH)) begin
            if (guard == TIMEOUT) begin
                timeouts++;
                $display("timed out waiting for a credit");
                return;
            end
            guard++;
            @(posedge clk);
            #1;
        end
        inst_req  = use_i;
        inst_addr = ia;
        d_req     = use_d;
        d_write   = wr;
        d_addr    = da;
        d_wdata   = wd;
        d_wmask   = wm;
        if (use_i) begin
            inst_spent++;
            exp_inst.push_back(ref_mem[word_idx(ia)]);
        end
        if (use_d) begin
            d_spent++;
            i = word_idx(da);
            if (wr) begin
                ref_mem[i] = (ref_mem[i] & ~wm) | (wd & wm); // old outside mask, new inside
            end else begin
                exp_data.push_back(ref_mem[i]);
                exp_data_cycle.push_back(cycle);
            end
        end
    endtask

    task automatic drain();
        int guard;
        guard = 0;
        @(posedge clk);
        #1;
        inst_req = 1'b0;
        d_req    = 1'b0;
        while (!(inst_spent == inst_back && d_spent == d_back &&
                 inst_seen == exp_inst.size() && d_seen == exp_data.size())) begin
            if (guard == TIMEOUT) begin
                timeouts++;
                $display("timed out waiting for outstanding requests to complete");
                return;
            end
            guard++;
            @(posedge clk);
        end
    endtask

    task automatic cfg_write(input int a, input int v);
        @(posedge clk);
        #1;
        cfg_we    = 1'b1;
        cfg_addr  = `CFG_ADDR_W'(a);
        cfg_wdata = `CFG_DATA_W'(v);
        @(posedge clk);
        #1;
        cfg_we = 1'b0;
    endtask

    task automatic cfg_check(input int a, input int v);
        @(posedge clk);
        #1;
        cfg_addr = `CFG_ADDR_W'(a);
        @(negedge clk);
        assert (cfg_rdata == `CFG_DATA_W'(v)) else begin
            check_errors++;
            $display("[ERROR] cfg_rdata got %h expected %h", cfg_rdata, `CFG_DATA_W'(v));
        end
    endtask

    task automatic mixed_reads();
        for (int i = 0; i < NADDR; i++) begin
            send(1'b1, addrs[i], 1'b1, 1'b0, addrs[(i + 3) % NADDR], '0, '0);
        end
        drain();
    endtask

    initial begin
        void'($urandom(32'h5c2c_23d9));
        rst = 1'b1;
        halt = 1'b0;
        inst_req = 1'b0;
        inst_addr = '0;
        d_req = 1'b0;
        d_write = 1'b0;
        d_addr = '0;
        d_wdata = '0;
        d_wmask = '0;
        cfg_we = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        cfg_check(`CFG_WAIT_ADDR, 0);
        cfg_check(`CFG_PRIO_ADDR, 0);
        repeat (4) @(posedge clk);

        for (int i = 0; i < NADDR; i++) begin
            addrs[i] = $urandom & 32'hffff_fffc; // random upper bits exercise aliasing
            send(1'b0, '0, 1'b1, 1'b1, addrs[i], $urandom, '1);
        end
        for (int i = 0; i < NADDR; i++) begin
            send(1'b0, '0, 1'b1, 1'b1, addrs[i], $urandom, $urandom);
        end
        for (int i = 0; i < NADDR; i++) begin
            send(1'b0, '0, 1'b1, 1'b0, addrs[i], '0, '0);
        end
        drain();

        mixed_reads();
        cfg_write(`CFG_PRIO_ADDR, 1);
        cfg_check(`CFG_PRIO_ADDR, 1);
        mixed_reads();

        // spend all credits with issue blocked
        @(posedge clk);
        #1;
        halt = 1'b1;
        inst_snap = inst_seen + inst_back;
        d_snap = d_seen + d_back;
        for (int k = 0; k < `REQ_DEPTH; k++) begin
            send(1'b1, addrs[k], 1'b1, 1'b0, addrs[k + 1], '0, '0);
        end
        @(posedge clk);
        #1;
        inst_req = 1'b0;
        d_req = 1'b0;
        repeat (10) @(posedge clk);
        assert (inst_seen + inst_back == inst_snap && d_seen + d_back == d_snap) else begin
            check_errors++;
            $display("credit or response returned while halt was high");
        end
        #1;
        halt = 1'b0;
        drain();

        cfg_write(`CFG_WAIT_ADDR, 5);
        cfg_check(`CFG_WAIT_ADDR, 5);
        min_lat = 6;
        for (int i = 0; i < NADDR; i++) begin
            send(1'b0, '0, 1'b1, 1'b0, addrs[i], '0, '0);
        end
        drain();

        total = value_errors + check_errors + timeouts + dut_i.props_i.fail_count;
        $display("value errors %0d, check errors %0d, timeouts %0d, property failures %0d",
                 value_errors, check_errors, timeouts, dut_i.props_i.fail_count);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verification/mem_subsys_props.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_subsys_props (
    input logic clk,
    input logic rst,
    input logic inst_req,
    input logic d_req,
    input logic inst_credit,
    input logic d_credit,
    input logic inst_rvalid,
    input logic d_rvalid,
    input logic cmd_valid,
    input logic cmd_write,
    input logic busy,
    input logic rvalid
);

    int   inst_occ;     // fifo occupancy seen from push and pop
    int   d_occ;
    logic read_out;     // memory read in flight
    logic seen_req;
    int   fail_push = 0;
    int   fail_credit = 0;
    int   fail_rvalid = 0;
    int   fail_reset = 0;
    int   fail_count;

    assign fail_count = fail_push + fail_credit + fail_rvalid + fail_reset;

    always_ff @(posedge clk) begin
        if (rst) begin
            inst_occ <= 0;
            d_occ    <= 0;
            read_out <= 1'b0;
            seen_req <= 1'b0;
        end else begin
            inst_occ <= inst_occ + int'(inst_req) - int'(inst_credit);
            d_occ    <= d_occ + int'(d_req) - int'(d_credit);
            if (cmd_valid && !busy && !cmd_write) begin
                read_out <= 1'b1;
            end else if (rvalid) begin
                read_out <= 1'b0;
            end
            if (inst_req || d_req) begin
                seen_req <= 1'b1;
            end
        end
    end

    push_not_full: assert property (@(posedge clk) disable iff (rst)
        (inst_req |-> inst_occ < `REQ_DEPTH) and (d_req |-> d_occ < `REQ_DEPTH))
        else begin
            fail_push++;
            $error("request pushed into a full fifo");
        end

    credit_not_empty: assert property (@(posedge clk) disable iff (rst)
        (inst_credit |-> inst_occ > 0) and (d_credit |-> d_occ > 0))
        else begin
            fail_credit++;
            $error("credit returned while the fifo was empty");
        end

    rvalid_outstanding: assert property (@(posedge clk) disable iff (rst)
        rvalid |-> read_out)
        else begin
            fail_rvalid++;
            $error("memory rvalid without a read outstanding");
        end

    quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
        !seen_req |-> !(inst_credit || d_credit || inst_rvalid || d_rvalid))
        else begin
            fail_reset++;
            $error("credit or rvalid seen before the first request");
        end

endmodule

bind mem_subsys_top mem_subsys_props props_i (.*);

// File: verilog/mem_subsys_top.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_subsys_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   halt,

    input  logic                   inst_req,
    input  logic [`MEM_ADDR_W-1:0] inst_addr,
    output logic                   inst_credit,
    output logic                   inst_rvalid,
    output logic [`MEM_DATA_W-1:0] inst_rdata,

    input  logic                   d_req,
    input  logic                   d_write,
    input  logic [`MEM_ADDR_W-1:0] d_addr,
    input  logic [`MEM_DATA_W-1:0] d_wdata,
    input  logic [`MEM_DATA_W-1:0] d_wmask,
    output logic                   d_credit,
    output logic                   d_rvalid,
    output logic [`MEM_DATA_W-1:0] d_rdata,

    input  logic                   cfg_we,
    input  logic [`CFG_ADDR_W-1:0] cfg_addr,
    input  logic [`CFG_DATA_W-1:0] cfg_wdata,
    output logic [`CFG_DATA_W-1:0] cfg_rdata
);

    logic                   i_valid;
    mem_pkg::inst_req_t     i_head;
    logic                   d_valid;
    mem_pkg::data_req_t     d_head;

    logic                   cmd_valid;
    logic                   cmd_write;
    logic [`MEM_ADDR_W-1:0] cmd_addr;
    logic [`MEM_DATA_W-1:0] cmd_wdata;
    logic [`MEM_DATA_W-1:0] cmd_wmask;
    logic                   busy;
    logic                   rvalid;
    logic [`MEM_DATA_W-1:0] rdata;

    mem_pkg::wait_t         wait_states;
    logic                   data_first;

    req_fifo #(.payload_t(mem_pkg::inst_req_t), .DEPTH(`REQ_DEPTH)) inst_fifo_i (
        .clk(clk), .rst(rst),
        .push(inst_req), .push_data(inst_addr),
        .pop(inst_credit), .head_valid(i_valid), .head_data(i_head)
    );

    // concatenation follows data_req_t field order
    req_fifo #(.payload_t(mem_pkg::data_req_t), .DEPTH(`REQ_DEPTH)) data_fifo_i (
        .clk(clk), .rst(rst),
        .push(d_req), .push_data({d_write, d_addr, d_wdata, d_wmask}),
        .pop(d_credit), .head_valid(d_valid), .head_data(d_head)
    );

    mem_port_arbiter arbiter_i (
        .clk(clk), .rst(rst), .halt(halt), .data_first(data_first),
        .i_valid(i_valid), .i_head(i_head), .i_pop(inst_credit),
        .d_valid(d_valid), .d_head(d_head), .d_pop(d_credit),
        .cmd_valid(cmd_valid), .cmd_write(cmd_write), .cmd_addr(cmd_addr),
        .cmd_wdata(cmd_wdata), .cmd_wmask(cmd_wmask),
        .busy(busy), .rvalid(rvalid), .rdata(rdata),
        .inst_rvalid(inst_rvalid), .inst_rdata(inst_rdata),
        .d_rvalid(d_rvalid), .d_rdata(d_rdata)
    );

    mem_array mem_i (
        .clk(clk),
        .cmd_valid(cmd_valid), .cmd_write(cmd_write), .cmd_addr(cmd_addr),
        .cmd_wdata(cmd_wdata), .cmd_wmask(cmd_wmask),
        .wait_states(wait_states),
        .busy(busy), .rvalid(rvalid), .rdata(rdata),
        .rst(rst)
    );

    mem_cfg_regs cfg_i (
        .clk(clk), .rst(rst),
        .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
        .cfg_rdata(cfg_rdata),
        .wait_states(wait_states), .data_first(data_first)
    );

endmodule

// File: verilog/mem_cfg_regs.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_cfg_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cfg_we,
    input  logic [`CFG_ADDR_W-1:0] cfg_addr,
    input  logic [`CFG_DATA_W-1:0] cfg_wdata,
    output logic [`CFG_DATA_W-1:0] cfg_rdata,
    output mem_pkg::wait_t         wait_states,
    output logic                   data_first
);

    logic sel_wait;
    logic sel_prio;

    assign sel_wait = (cfg_addr == `CFG_ADDR_W'(`CFG_WAIT_ADDR));
    assign sel_prio = (cfg_addr == `CFG_ADDR_W'(`CFG_PRIO_ADDR));

    always_ff @(posedge clk) begin
        if (rst) begin
            wait_states <= '0;
            data_first  <= 1'b0; // fetch first out of reset
        end else if (cfg_we) begin
            if (sel_wait) begin
                wait_states <= cfg_wdata[2:0];
            end
            if (sel_prio) begin
                data_first <= cfg_wdata[0];
            end
        end
    end

    // unmapped addresses read as zero
    always_comb begin
        cfg_rdata = '0;
        if (sel_wait) begin
            cfg_rdata[2:0] = wait_states;
        end else if (sel_prio) begin
            cfg_rdata[0] = data_first;
        end
    end

endmodule

// File: verilog/mem_array.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_array (
    input  logic                   clk,
    input  logic                   cmd_valid,
    input  logic                   cmd_write,
    input  logic [`MEM_ADDR_W-1:0] cmd_addr,
    input  logic [`MEM_DATA_W-1:0] cmd_wdata,
    input  logic [`MEM_DATA_W-1:0] cmd_wmask,
    input  mem_pkg::wait_t         wait_states,
    output logic                   busy,
    output logic                   rvalid,
    output logic [`MEM_DATA_W-1:0] rdata,
    input  logic                   rst
);

    localparam int IDX_W = $clog2(`MEM_WORDS);

    logic [`MEM_DATA_W-1:0] words [`MEM_WORDS];
    logic [IDX_W-1:0]       idx;
    logic                   accept;
    logic                   active;  // access in progress
    logic                   is_read;
    mem_pkg::wait_t         remain;  // cycles left before completion

    assign idx    = cmd_addr[IDX_W+1:2]; // word aligned, upper bits dropped
    assign accept = cmd_valid && !active;

    assign busy   = active;
    assign rvalid = active && is_read && (remain == '0);

    always_ff @(posedge clk) begin
        if (accept) begin
            if (cmd_write) begin
                words[idx] <= (words[idx] & ~cmd_wmask) | (cmd_wdata & cmd_wmask);
            end else begin
                rdata <= words[idx]; // held until rvalid
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active  <= 1'b0;
            is_read <= 1'b0;
            remain  <= '0;
        end else if (accept) begin
            active  <= 1'b1;
            is_read <= !cmd_write;
            remain  <= wait_states;
        end else if (active) begin
            if (remain == '0) begin
                active <= 1'b0;
            end else begin
                remain <= remain - 1'b1;
            end
        end
    end

endmodule

// File: verilog/mem_port_arbiter.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_port_arbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   halt,
    input  logic                   data_first,

    input  logic                   i_valid,
    input  mem_pkg::inst_req_t     i_head,
    output logic                   i_pop,

    input  logic                   d_valid,
    input  mem_pkg::data_req_t     d_head,
    output logic                   d_pop,

    output logic                   cmd_valid,
    output logic                   cmd_write,
    output logic [`MEM_ADDR_W-1:0] cmd_addr,
    output logic [`MEM_DATA_W-1:0] cmd_wdata,
    output logic [`MEM_DATA_W-1:0] cmd_wmask,
    input  logic                   busy,
    input  logic                   rvalid,
    input  logic [`MEM_DATA_W-1:0] rdata,

    output logic                   inst_rvalid,
    output logic [`MEM_DATA_W-1:0] inst_rdata,
    output logic                   d_rvalid,
    output logic [`MEM_DATA_W-1:0] d_rdata
);

    typedef enum logic [0:0] {
        idle,
        wait_read
    } state_t;

    state_t state;
    logic   owner_data; // read in flight belongs to data port
    logic   take_data;
    logic   accept;

    // data head wins only when it is alone or has priority
    assign take_data = d_valid && (data_first || !i_valid);

    assign cmd_valid = (state == idle) && !halt && (i_valid || d_valid);
    assign cmd_write = take_data && d_head.write;
    assign cmd_addr  = take_data ? d_head.addr : i_head;
    assign cmd_wdata = d_head.wdata;
    assign cmd_wmask = d_head.wmask;

    assign accept = cmd_valid && !busy;
    assign i_pop  = accept && !take_data; // doubles as inst credit
    assign d_pop  = accept && take_data;  // doubles as data credit

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= idle;
            owner_data <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (accept && !cmd_write) begin
                        state      <= wait_read;
                        owner_data <= take_data;
                    end
                end
                wait_read: begin
                    if (rvalid) begin
                        state <= idle; // writes never get here
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // read data is steered to whoever issued the read
    assign inst_rvalid = (state == wait_read) && rvalid && !owner_data;
    assign d_rvalid    = (state == wait_read) && rvalid && owner_data;
    assign inst_rdata  = rdata;
    assign d_rdata     = rdata;

endmodule

// File: verilog/req_fifo.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module req_fifo #(
    parameter type payload_t = mem_pkg::inst_req_t,
    parameter int  DEPTH     = `REQ_DEPTH
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output logic     head_valid,
    output payload_t head_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t           slots [DEPTH];
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   wr_ptr;
    logic [CNT_W-1:0]   count;

    assign head_valid = (count != '0);
    assign head_data  = slots[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= push_data; // sender never pushes while full
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: verilog/mem_pkg.sv
`include "mem_macros.svh"

package mem_pkg;

    // fetch request carries only the byte address
    typedef logic [`MEM_ADDR_W-1:0] inst_req_t;

    // load/store request, mask is one bit per data bit
    typedef struct packed {
        logic                   write;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_DATA_W-1:0] wdata;
        logic [`MEM_DATA_W-1:0] wmask;
    } data_req_t;

    typedef logic [2:0] wait_t; // extra read latency in cycles

endpackage

// File: verilog/mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

`define MEM_ADDR_W    32   // byte address width
`define MEM_DATA_W    32   // word width
`define MEM_WORDS     1024 // depth in words
`define REQ_DEPTH     2    // fifo depth and credits per port
`define CFG_ADDR_W    8
`define CFG_DATA_W    8
`define CFG_WAIT_ADDR 0
`define CFG_PRIO_ADDR 1

`endif
